// File: rtl/pmp_defines.svh
// PMP configuration constants
// entry count, address width and the largest NAPOT region that is built

`ifndef PMP_DEFINES_SVH
`define PMP_DEFINES_SVH

// number of rules
`define PMP_N_ENTRIES 16

// byte address and PMP address register width
`define PMP_ADDR_W 32

// NAPOT trailing ones limit where 15 gives 256 KB
`define PMP_NAPOT_MAX 15

`endif

// File: rtl/riscv_priv_pkg.sv
// RISC-V privilege levels
// encoding follows the privileged spec where level 2 is reserved

package riscv_priv_pkg;

   typedef enum logic [1:0]
   {
      PRIV_LVL_U = 2'b00,
      PRIV_LVL_S = 2'b01,
      PRIV_LVL_M = 2'b11
   } priv_lvl_e;

endpackage

// File: rtl/pmp_pkg.sv
// PMP rule types
// address matching modes, the raw config byte and the word address

`include "pmp_defines.svh"

package pmp_pkg;

   // address matching mode from the A field of pmpcfg
   typedef enum logic [1:0]
   {
      PMP_OFF   = 2'd0,
      PMP_TOR   = 2'd1,
      PMP_NA4   = 2'd2,
      PMP_NAPOT = 2'd3
   } pmp_mode_e;

   // one pmpcfg byte with the msb first
   typedef struct packed
   {
      logic      lock;
      logic [1:0] rsvd;
      pmp_mode_e mode;
      logic      x;
      logic      w;
      logic      r;
   } pmp_cfg_t;

   // byte address bits 31..2
   typedef logic [`PMP_ADDR_W-3:0] pmp_waddr_t;

endpackage

// File: rtl/pmp_rule_if.sv
// PMP decoded rule table
// carries per-entry enable, permissions and region from decoder to checkers

`timescale 1ns/1ps

`include "pmp_defines.svh"

interface pmp_rule_if;
   import pmp_pkg::*;

   logic       [`PMP_N_ENTRIES-1:0] en;
   logic       [`PMP_N_ENTRIES-1:0] perm_r;
   logic       [`PMP_N_ENTRIES-1:0] perm_w;
   logic       [`PMP_N_ENTRIES-1:0] perm_x;
   pmp_mode_e  [`PMP_N_ENTRIES-1:0] mode;
   pmp_waddr_t [`PMP_N_ENTRIES-1:0] base;
   pmp_waddr_t [`PMP_N_ENTRIES-1:0] limit;
   pmp_waddr_t [`PMP_N_ENTRIES-1:0] mask;

   modport dec (output en, perm_r, perm_w, perm_x, mode, base, limit, mask);
   modport chk (input  en, perm_r, perm_w, perm_x, mode, base, limit, mask);

endinterface

// File: rtl/pmp_rule_decode.sv
// PMP rule decoder
// expands pmpaddr/pmpcfg pairs into enable, permissions, base, limit and
// mask for every entry in purely combinational logic

`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_rule_decode
(
   input  logic [`PMP_N_ENTRIES-1:0][`PMP_ADDR_W-1:0] pmp_addr_i,
   input  pmp_pkg::pmp_cfg_t [`PMP_N_ENTRIES-1:0]     pmp_cfg_i,
   pmp_rule_if.dec                                     rules
);
   import pmp_pkg::*;

   // number of consecutive ones from bit 0 upwards
   function automatic logic [5:0] trailing_ones(input logic [`PMP_ADDR_W-1:0] a);
      logic [5:0] cnt;
      logic       run;
      cnt = '0;
      run = 1'b1;
      for (int b = 0; b < `PMP_ADDR_W; b++)
      begin
         run = run & a[b];
         cnt = cnt + 6'(run);
      end
      return cnt;
   endfunction

   ////////////////////////////////////////
   // region expansion
   ////////////////////////////////////////
   always_comb
   begin : decode_entries
      pmp_waddr_t waddr;
      pmp_waddr_t prev;
      pmp_waddr_t base_v;
      pmp_waddr_t limit_v;
      pmp_waddr_t mask_v;
      logic       en_v;
      logic [5:0] ones;

      prev = '0;
      for (int i = 0; i < `PMP_N_ENTRIES; i++)
      begin
         waddr   = pmp_addr_i[i][`PMP_ADDR_W-3:0];
         en_v    = 1'b0;
         base_v  = '0;
         limit_v = '0;
         mask_v  = '1;
         ones    = trailing_ones(pmp_addr_i[i]);

         case (pmp_cfg_i[i].mode)
            PMP_TOR:
            begin
               // previous entry is the bottom and own address the exclusive top
               en_v    = 1'b1;
               base_v  = prev;
               limit_v = waddr;
            end
            PMP_NA4:
            begin
               en_v   = 1'b1;
               base_v = waddr;
            end
            PMP_NAPOT:
            begin
               // oversized regions stay disabled
               if (ones <= 6'(`PMP_NAPOT_MAX))
               begin
                  en_v   = 1'b1;
                  mask_v = {(`PMP_ADDR_W-2){1'b1}} << (ones + 6'd1);
                  base_v = waddr & mask_v;
               end
            end
            default:
            begin
               en_v = 1'b0;
            end
         endcase

         rules.en[i]     = en_v;
         rules.perm_r[i] = pmp_cfg_i[i].r;
         rules.perm_w[i] = pmp_cfg_i[i].w;
         rules.perm_x[i] = pmp_cfg_i[i].x;
         rules.mode[i]   = pmp_cfg_i[i].mode;
         rules.base[i]   = base_v;
         rules.limit[i]  = limit_v;
         rules.mask[i]   = mask_v;

         prev = waddr;
      end
   end

   // unused entries keep a zero base
   always_comb
   begin
      for (int i = 0; i < `PMP_N_ENTRIES; i++)
      begin
         assert final (rules.en[i] || rules.base[i] == '0)
            else $error("pmp entry %0d disabled with base %h", i, rules.base[i]);
      end
   end

endmodule

// File: rtl/pmp_port_check.sv
// PMP access checker for one path
// matches the access against the decoded rules and gates request and grant;
// FETCH_SIDE selects execute permission instead of read/write

`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_port_check
#(
   parameter bit FETCH_SIDE = 1'b0
)
(
   pmp_rule_if.chk                  rules,
   input  riscv_priv_pkg::priv_lvl_e priv_lvl_i,

   input  logic                     req_i,
   input  logic [`PMP_ADDR_W-1:0]   addr_i,
   input  logic                     we_i,
   input  logic                     gnt_i,

   output logic                     req_o,
   output logic                     gnt_o,
   output logic                     denied_o
);
   import pmp_pkg::*;
   import riscv_priv_pkg::*;

   pmp_waddr_t                waddr;
   logic [`PMP_N_ENTRIES-1:0] perm_ok;
   logic [`PMP_N_ENTRIES-1:0] region_match;
   logic [`PMP_N_ENTRIES-1:0] entry_hit;
   logic                      bypass;
   logic                      allowed;

   assign waddr = addr_i[`PMP_ADDR_W-1:2];

   ////////////////////////////////////////
   // per-entry match
   ////////////////////////////////////////
   always_comb
   begin
      for (int j = 0; j < `PMP_N_ENTRIES; j++)
      begin
         // required permission for this access
         if (FETCH_SIDE)
            perm_ok[j] = rules.perm_x[j];
         else
            perm_ok[j] = we_i ? rules.perm_w[j] : rules.perm_r[j];

         case (rules.mode[j])
            PMP_TOR:   region_match[j] = (waddr >= rules.base[j]) && (waddr < rules.limit[j]);
            PMP_NA4:   region_match[j] = (waddr == rules.base[j]);
            PMP_NAPOT: region_match[j] = ((waddr & rules.mask[j]) == rules.base[j]);
            default:   region_match[j] = 1'b0;
         endcase
      end
   end

   assign entry_hit = rules.en & perm_ok & region_match;

   ////////////////////////////////////////
   // gating
   ////////////////////////////////////////
   // machine mode skips every rule
   assign bypass  = (priv_lvl_i == PRIV_LVL_M);
   assign allowed = bypass || (|entry_hit);

   assign req_o    = allowed ? req_i : 1'b0;
   assign gnt_o    = allowed ? gnt_i : 1'b0;
   assign denied_o = allowed ? 1'b0  : req_i;

   // a NAPOT base with bits below its mask could never match
   always_comb
   begin
      for (int j = 0; j < `PMP_N_ENTRIES; j++)
      begin
         assert final (!(rules.en[j] && rules.mode[j] == PMP_NAPOT)
                       || (rules.base[j] & ~rules.mask[j]) == '0)
            else $error("pmp entry %0d napot base %h outside mask %h",
                        j, rules.base[j], rules.mask[j]);
      end
   end

endmodule

// File: rtl/pmp_err_fsm.sv
// PMP data error holder
// turns a one-cycle denial into a level error for the load/store unit
// that holds until the core acknowledges it

`timescale 1ns/1ps

module pmp_err_fsm
(
   input  logic clk,
   input  logic rst_n,
   input  logic denied_i,
   input  logic err_ack_i,
   output logic err_o
);

   typedef enum logic
   {
      IDLE       = 1'b0,
      GIVE_ERROR = 1'b1
   } err_state_e;

   err_state_e state_q;
   err_state_e state_d;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (denied_i)
               state_d = GIVE_ERROR;
         end
         GIVE_ERROR:
         begin
            // further denials are dropped until the ack
            if (err_ack_i)
               state_d = IDLE;
         end
         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   assign err_o = (state_q == GIVE_ERROR);

   a_err_clears_on_ack: assert property (
      @(posedge clk) disable iff (!rst_n) $fell(err_o) |-> $past(err_ack_i))
      else $error("data error dropped without acknowledge");

endmodule

// File: rtl/pmp_top.sv
// PMP unit top level
// checks data and fetch accesses of a 32-bit core against the PMP rules
// and gates the request/grant handshake of each path

`timescale 1ns/1ps

`include "pmp_defines.svh"

module pmp_top
(
   input  logic                                       clk,
   input  logic                                       rst_n,

   input  riscv_priv_pkg::priv_lvl_e                  priv_lvl_i,

   input  logic [`PMP_N_ENTRIES-1:0][`PMP_ADDR_W-1:0] pmp_addr_i,
   input  pmp_pkg::pmp_cfg_t [`PMP_N_ENTRIES-1:0]     pmp_cfg_i,

   // data side from the pipeline
   input  logic                                       data_req_i,
   input  logic [`PMP_ADDR_W-1:0]                     data_addr_i,
   input  logic                                       data_we_i,
   output logic                                       data_gnt_o,
   // data side towards memory
   output logic                                       data_req_o,
   input  logic                                       data_gnt_i,
   output logic [`PMP_ADDR_W-1:0]                     data_addr_o,
   output logic                                       data_err_o,
   input  logic                                       data_err_ack_i,

   // fetch side from the pipeline
   input  logic                                       instr_req_i,
   input  logic [`PMP_ADDR_W-1:0]                     instr_addr_i,
   output logic                                       instr_gnt_o,
   // fetch side towards the prefetch buffer
   output logic                                       instr_req_o,
   input  logic                                       instr_gnt_i,
   output logic [`PMP_ADDR_W-1:0]                     instr_addr_o,
   output logic                                       instr_err_o
);

   logic data_denied;

   pmp_rule_if rule_bus ();

   pmp_rule_decode i_rule_decode
   (
      .pmp_addr_i (pmp_addr_i),
      .pmp_cfg_i  (pmp_cfg_i),
      .rules      (rule_bus)
   );

   ////////////////////////////////////////
   // data path
   ////////////////////////////////////////
   pmp_port_check #(.FETCH_SIDE(1'b0)) i_data_check
   (
      .rules      (rule_bus),
      .priv_lvl_i (priv_lvl_i),
      .req_i      (data_req_i),
      .addr_i     (data_addr_i),
      .we_i       (data_we_i),
      .gnt_i      (data_gnt_i),
      .req_o      (data_req_o),
      .gnt_o      (data_gnt_o),
      .denied_o   (data_denied)
   );

   pmp_err_fsm i_data_err_fsm
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .denied_i  (data_denied),
      .err_ack_i (data_err_ack_i),
      .err_o     (data_err_o)
   );

   assign data_addr_o = data_addr_i;

   ////////////////////////////////////////
   // fetch path
   ////////////////////////////////////////
   // fetch errors go straight back to the prefetcher
   pmp_port_check #(.FETCH_SIDE(1'b1)) i_instr_check
   (
      .rules      (rule_bus),
      .priv_lvl_i (priv_lvl_i),
      .req_i      (instr_req_i),
      .addr_i     (instr_addr_i),
      .we_i       (1'b0),
      .gnt_i      (instr_gnt_i),
      .req_o      (instr_req_o),
      .gnt_o      (instr_gnt_o),
      .denied_o   (instr_err_o)
   );

   assign instr_addr_o = instr_addr_i;

   // an error only appears after a request that was held back from memory
   a_err_after_block: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(data_err_o) |-> $past(data_req_i && !data_req_o))
      else $error("data error without a blocked data request");

endmodule

// File: tb/pmp_ref_model.svh
// PMP reference model
// every rule is a half-open range of word addresses and an access is allowed
// by any active rule that covers it and grants the needed permission

`ifndef PMP_REF_MODEL_SVH
`define PMP_REF_MODEL_SVH

// kind is 0 for a load, 1 for a store, 2 for a fetch
function automatic bit model_allows(
   input pmp_cfg_t [`PMP_N_ENTRIES-1:0]               cfgs,
   input logic [`PMP_N_ENTRIES-1:0][`PMP_ADDR_W-1:0] addrs,
   input priv_lvl_e                                   lvl,
   input longint                                      wa,
   input int                                          kind
);
   longint word;
   longint prev;
   longint lo;
   longint hi;
   int     ones;
   bit     perm;

   if (lvl == PRIV_LVL_M)
      return 1'b1;
   prev = 0;
   for (int i = 0; i < `PMP_N_ENTRIES; i++)
   begin
      word = longint'(addrs[i][`PMP_ADDR_W-3:0]);
      ones = 0;
      while (ones < `PMP_ADDR_W && addrs[i][ones])
         ones++;
      // an empty range for OFF
      lo = 0;
      hi = 0;
      if (cfgs[i].mode == PMP_TOR)
      begin
         lo = prev;
         hi = word;
      end
      else if (cfgs[i].mode == PMP_NA4)
      begin
         lo = word;
         hi = word + 1;
      end
      // NAPOT covers 2^(ones+1) words and bigger regions are not built
      else if (cfgs[i].mode == PMP_NAPOT && ones <= `PMP_NAPOT_MAX)
      begin
         lo = (word >> (ones + 1)) << (ones + 1);
         hi = lo + (longint'(1) << (ones + 1));
      end
      perm = (kind == 2) ? cfgs[i].x : ((kind == 1) ? cfgs[i].w : cfgs[i].r);
      if (perm && wa >= lo && wa < hi)
         return 1'b1;
      prev = word;
   end
   return 1'b0;
endfunction

`endif

// File: tb/tb_pmp.sv
// PMP unit testbench
// random rule tables and accesses against a reference model together with
// the data error handshake and oversized NAPOT regions

`timescale 1ns/1ps

`include "pmp_defines.svh"

module tb_pmp;
   import pmp_pkg::*;
   import riscv_priv_pkg::*;

   `include "pmp_ref_model.svh"

   logic                                       clk;
   logic                                       rst_n;
   priv_lvl_e                                  priv_lvl_i;
   logic [`PMP_N_ENTRIES-1:0][`PMP_ADDR_W-1:0] pmp_addr_i;
   pmp_cfg_t [`PMP_N_ENTRIES-1:0]              pmp_cfg_i;
   logic [`PMP_ADDR_W-1:0]                     data_addr_i;
   logic [`PMP_ADDR_W-1:0]                     data_addr_o;
   logic [`PMP_ADDR_W-1:0]                     instr_addr_i;
   logic [`PMP_ADDR_W-1:0]                     instr_addr_o;
   logic                                       data_req_i;
   logic                                       data_we_i;
   logic                                       data_gnt_i;
   logic                                       data_err_ack_i;
   logic                                       instr_req_i;
   logic                                       instr_gnt_i;
   logic                                       data_req_o;
   logic                                       data_gnt_o;
   logic                                       data_err_o;
   logic                                       instr_req_o;
   logic                                       instr_gnt_o;
   logic                                       instr_err_o;
   // state of the data error expected after the coming edge
   bit                                         err_exp;
   int                                         errors;
   int                                         failed;
   int                                         mark;

   pmp_top i_pmp_top (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   task automatic expect_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Error: %s is %0h, expected %0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name);
      $display("test %-16s %s", name, (errors == mark) ? "ok" : "failed");
      failed += (errors != mark) ? 1 : 0;
      mark = errors;
   endtask

   ////////////////////////////////////////
   // checking
   ////////////////////////////////////////
   // runs 9 ns before the next edge when all outputs have settled
   task automatic finish_cycle();
      bit d_ok;
      bit i_ok;
      #90;
      d_ok = model_allows(pmp_cfg_i, pmp_addr_i, priv_lvl_i,
                          longint'(data_addr_i[`PMP_ADDR_W-1:2]), data_we_i ? 1 : 0);
      i_ok = model_allows(pmp_cfg_i, pmp_addr_i, priv_lvl_i,
                          longint'(instr_addr_i[`PMP_ADDR_W-1:2]), 2);
      expect_value("data_req_o", data_req_o, d_ok & data_req_i);
      expect_value("data_gnt_o", data_gnt_o, d_ok & data_gnt_i);
      expect_value("data_addr_o", data_addr_o, data_addr_i);
      expect_value("data_err_o", data_err_o, err_exp);
      expect_value("instr_req_o", instr_req_o, i_ok & instr_req_i);
      expect_value("instr_gnt_o", instr_gnt_o, i_ok & instr_gnt_i);
      expect_value("instr_err_o", instr_err_o, !i_ok & instr_req_i);
      expect_value("instr_addr_o", instr_addr_o, instr_addr_i);
      // denials are dropped while an error is held
      if (!err_exp)
         err_exp = data_req_i && !d_ok;
      else if (data_err_ack_i)
         err_exp = 1'b0;
   endtask

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   // byte address near a rule address or sometimes anywhere in the window
   function automatic logic [`PMP_ADDR_W-1:0] near_rule();
      logic [`PMP_ADDR_W-1:0] w;
      w = pmp_addr_i[$urandom % `PMP_N_ENTRIES] + ($urandom % 5) - 32'd2;
      if ($urandom % 4 == 0)
         w = $urandom & 32'h3_ffff;
      return {w[`PMP_ADDR_W-3:0], 2'($urandom)};
   endfunction

   // rules stay in a small word window so that accesses hit often
   task automatic draw_access(input priv_lvl_e lvl, input bit data_on, input bit fetch_on);
      for (int i = 0; i < `PMP_N_ENTRIES; i++)
      begin
         pmp_cfg_i[i]  = pmp_cfg_t'(8'($urandom));
         pmp_addr_i[i] = ($urandom & 32'h3_ffff) | ((32'd1 << ($urandom % 18)) - 32'd1);
      end
      priv_lvl_i     = (lvl == PRIV_LVL_M || 1'($urandom)) ? lvl : PRIV_LVL_S;
      data_req_i     = data_on & 1'($urandom);
      data_we_i      = 1'($urandom);
      data_gnt_i     = 1'($urandom);
      data_err_ack_i = ($urandom % 4) == 0;
      instr_req_i    = fetch_on & 1'($urandom);
      instr_gnt_i    = 1'($urandom);
      data_addr_i    = near_rule();
      instr_addr_i   = near_rule();
   endtask

   task automatic idle_cycle(input bit ack);
      @(posedge clk);
      #1;
      data_req_i     = 1'b0;
      instr_req_i    = 1'b0;
      data_err_ack_i = ack;
      finish_cycle();
   endtask

   task automatic random_run(input string name, input int cycles, input priv_lvl_e lvl,
                             input bit data_on, input bit fetch_on);
      repeat (cycles)
      begin
         @(posedge clk);
         #1;
         draw_access(lvl, data_on, fetch_on);
         finish_cycle();
      end
      report_test(name);
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////
   task automatic error_handshake_test();
      int tries;
      tries = 0;
      while (err_exp && tries < 8)
      begin
         idle_cycle(1'b1);
         tries++;
      end
      // look for a user access that no rule allows
      tries = 0;
      @(posedge clk);
      #1;
      do
      begin
         draw_access(PRIV_LVL_U, 1'b1, 1'b0);
         data_req_i     = 1'b1;
         data_err_ack_i = 1'b0;
         tries++;
      end
      while (tries < 200 && model_allows(pmp_cfg_i, pmp_addr_i, priv_lvl_i,
                                         longint'(data_addr_i[`PMP_ADDR_W-1:2]), data_we_i));
      finish_cycle();
      assert (err_exp)
      else
      begin
         $display("no denied data request found within 200 tries");
         errors++;
      end
      repeat (1 + $urandom % 6)
      begin
         idle_cycle(1'b0);
         expect_value("data_err_o", data_err_o, 1);
      end
      idle_cycle(1'b1);
      idle_cycle(1'b0);
      expect_value("data_err_o", data_err_o, 0);
      report_test("error handshake");
   endtask

   task automatic oversized_napot_test();
      int                     t;
      int                     k;
      logic [`PMP_ADDR_W-1:0] m;
      logic [`PMP_ADDR_W-1:0] w;
      repeat (20)
      begin
         @(posedge clk);
         #1;
         draw_access(PRIV_LVL_U, 1'b1, 1'b1);
         // t trailing ones with at least one more than the largest built region
         t = `PMP_NAPOT_MAX + 1 + int'($urandom % 3);
         m = (32'd1 << (t + 1)) - 32'd1;
         w = (($urandom << (t + 1)) | (m >> 1)) & 32'h3fff_ffff;
         k = int'($urandom % `PMP_N_ENTRIES);
         pmp_cfg_i     = '0;
         pmp_addr_i    = '0;
         pmp_cfg_i[k]  = pmp_cfg_t'(8'h1f);
         pmp_addr_i[k] = w;
         w = (w & ~m) | ($urandom & m);
         data_req_i    = 1'b1;
         instr_req_i   = 1'b1;
         data_addr_i   = {w[`PMP_ADDR_W-3:0], 2'b00};
         instr_addr_i  = {w[`PMP_ADDR_W-3:0], 2'b00};
         finish_cycle();
         expect_value("data_req_o", data_req_o, 0);
         expect_value("instr_err_o", instr_err_o, 1);
      end
      report_test("oversized napot");
   endtask

   initial
   begin
      void'($urandom(32'h2591_f001));
      errors         = 0;
      failed         = 0;
      mark           = 0;
      err_exp        = 1'b0;
      rst_n          = 1'b0;
      priv_lvl_i     = PRIV_LVL_M;
      pmp_addr_i     = '0;
      pmp_cfg_i      = '0;
      data_req_i     = 1'b0;
      data_addr_i    = '0;
      data_we_i      = 1'b0;
      data_gnt_i     = 1'b0;
      data_err_ack_i = 1'b0;
      instr_req_i    = 1'b0;
      instr_addr_i   = '0;
      instr_gnt_i    = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      finish_cycle();
      report_test("reset");
      random_run("machine bypass", 200, PRIV_LVL_M, 1'b1, 1'b1);
      random_run("data path", 300, PRIV_LVL_U, 1'b1, 1'b0);
      random_run("fetch path", 300, PRIV_LVL_U, 1'b0, 1'b1);
      error_handshake_test();
      oversized_napot_test();
      $display("6 tests, %0d failed, %0d errors", failed, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: compile.f
+incdir+rtl
+incdir+tb
rtl/riscv_priv_pkg.sv
rtl/pmp_pkg.sv
rtl/pmp_rule_if.sv
rtl/pmp_rule_decode.sv
rtl/pmp_port_check.sv
rtl/pmp_err_fsm.sv
rtl/pmp_top.sv
tb/tb_pmp.sv

// File: Makefile
# Verilator build and run of the PMP unit testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pmp -f compile.f -o tb_pmp
	./obj_dir/tb_pmp | tee sim.log
	grep -qx '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
